/* cpu8080_core.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/program_counter.sv
rtl/sequencer.sv
rtl/cpu8080_core.sv
test/clock_gen.sv
test/tb_cpu8080_core.sv

/* Bender.yml */
package:
  name: cpu8080_core

export_include_dirs:
  - rtl

sources:
  - rtl/isa_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/alu.sv
  - rtl/register_file.sv
  - rtl/program_counter.sv
  - rtl/sequencer.sv
  - rtl/cpu8080_core.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/tb_cpu8080_core.sv

/* test/cpu_stimulus.mem */
// Program image at 00 to 3F with one 8080 byte per entry
// Records from 40 hold test number, port and data, and test FF ends the list
@00
06 5A 48 79 2E 3C 55 5A    // MVI B / MOV C,B / MOV A,C / MVI L / MOV D,L / MOV E,D
D3 10 7B D3 11             // OUT 10 / MOV A,E / OUT 11
80 CE 7A 99 D3 20          // ADD B / ACI 7A / SBB C / OUT 20
D6 35 A2 F6 C3 AB 3C 3D    // SUI 35 / ANA D / ORI C3 / XRA E / INR A / DCR A
D3 21                      // OUT 21
FA 22 00 D3 40             // JM taken past OUT 40
B8 DA 28 00 D3 41          // CMP B then JC not taken into OUT 41
37 2F 17 D2 30 00 D3 42    // STC / CMA / RAL then JNC taken past OUT 42
3F 0F F2 37 00 D3 43       // CMC / RRC then JP not taken since S is set
C3 3B 00 76 D3 50 76 00 00 // JMP over HLT / OUT 50 / HLT
@40
02 10 5A
02 11 3C
03 20 B5
03 21 FF
04 41 FF
04 43 80
05 50 80
FF 00 00

/* test/tb_cpu8080_core.sv */
`timescale 1ns/1ps

module tb_cpu8080_core;

	logic        i_clk;
	logic        i_rst;
	logic        i_ready = 1'b0;
	logic [7:0]  i_dat_r = 8'h00;
	logic [15:0] o_addr;
	logic        o_read;
	logic        o_write;
	logic [7:0]  o_dat_w;
	logic        o_io;

	// Program image in 00 to 3F and port write records from 40
	logic [7:0]  stim [0:127];
	int          n_rec;
	int          widx;
	int          passed;
	int          failed;
	int          errors [1:6];
	bit          reported [1:6];

	// Instruction stream tracking
	int          bytes_left;
	logic [7:0]  cur_op;
	logic [7:0]  jmp_lo;
	logic [15:0] exp_fetch = 16'h0000;
	logic [15:0] alt_fetch = 16'h0000;
	bit          alt_valid;
	bit          halted;

	clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_gen_inst (
		.o_clk(i_clk),
		.o_rst(i_rst)
	);

	cpu8080_core cpu8080_core_inst (
		.i_clk(i_clk), .i_rst(i_rst), .i_ready(i_ready), .i_dat_r(i_dat_r),
		.o_addr(o_addr), .o_read(o_read), .o_write(o_write), .o_dat_w(o_dat_w), .o_io(o_io)
	);

	function automatic string test_name(input int t);
		case (t)
			1: return "reset";
			2: return "moves";
			3: return "alu";
			4: return "flags and conditional jumps";
			5: return "jumps";
			default: return "wait states and halt";
		endcase
	endfunction

	// 8080 encoding lengths for the kept instruction groups
	function automatic bit is_jump(input logic [7:0] op);
		return (op == 8'hC3) || ((op & 8'hC7) == 8'hC2);
	endfunction

	function automatic int op_length(input logic [7:0] op);
		if (is_jump(op)) return 3;
		if (op == 8'hD3 || (op & 8'hC7) == 8'h06 || (op & 8'hC7) == 8'hC6) return 2;
		return 1;
	endfunction

	task automatic report_test(input int t);
		reported[t] = 1'b1;
		if (errors[t] == 0) begin
			$display("Test %0d %s passed", t, test_name(t));
			passed++;
		end else begin
			$display("Test %0d %s failed with %0d errors", t, test_name(t), errors[t]);
			failed++;
		end
	endtask

	// **************************************************
	// Bus monitor
	// **************************************************
	task automatic track_read(input logic [15:0] addr, input logic [7:0] data);
		logic [15:0] target;
		assert (addr < 16'd64) else begin
			$display("Read outside the program image at address %h", addr);
			errors[5]++;
		end
		if (bytes_left == 0) begin
			assert (addr == exp_fetch || (alt_valid && addr == alt_fetch)) else begin
				$display("Error at %0d ns: o_addr fetch expected %h got %h",
				         $time, exp_fetch, addr);
				errors[5]++;
			end
			cur_op     = data;
			bytes_left = op_length(data) - 1;
			exp_fetch  = addr + op_length(data);
			alt_valid  = 1'b0;
			if (data == 8'h76) halted = 1'b1;
		end else begin
			bytes_left--;
			if (bytes_left == 1) begin
				jmp_lo = data;
			end else if (is_jump(cur_op)) begin
				target = {data, jmp_lo};
				// Conditional jumps may land on either address
				if (cur_op == 8'hC3) begin
					exp_fetch = target;
				end else begin
					alt_fetch = target;
					alt_valid = 1'b1;
				end
			end
		end
	endtask

	task automatic check_write();
		int t;
		assert (widx < n_rec) else begin
			$display("Unexpected port write to %h after the expected list ended", o_addr);
			errors[6]++;
		end
		if (widx < n_rec) begin
			t = stim[64 + 3 * widx];
			assert (o_addr == {2{stim[65 + 3 * widx]}}) else begin
				$display("Error at %0d ns: o_addr expected %h got %h",
				         $time, {2{stim[65 + 3 * widx]}}, o_addr);
				errors[t]++;
			end
			assert (o_dat_w == stim[66 + 3 * widx]) else begin
				$display("Error at %0d ns: o_dat_w expected %h got %h",
				         $time, stim[66 + 3 * widx], o_dat_w);
				errors[t]++;
			end
			assert (o_io) else begin
				$display("Error at %0d ns: o_io expected 1 got %b", $time, o_io);
				errors[t]++;
			end
			widx++;
			if (widx < n_rec && stim[64 + 3 * widx] != t) report_test(t);
		end
	endtask

	// Memory model with 0 to 3 wait cycles per bus cycle
	initial begin
		bit pending;
		int wait_left;
		void'($urandom(75));
		pending = 1'b0;
		forever begin
			@(posedge i_clk);
			if (i_rst) begin
				i_ready <= 1'b0;
				pending = 1'b0;
			end else if (i_ready) begin
				// Cycle completes on this edge
				i_ready <= 1'b0;
				pending = 1'b0;
				if (o_read) track_read(o_addr, i_dat_r);
				if (o_write) check_write();
			end else if (o_read || o_write) begin
				if (!pending) begin
					pending = 1'b1;
					wait_left = $urandom % 4;
				end
				if (wait_left == 0) begin
					i_ready <= 1'b1;
					i_dat_r <= o_read ? stim[o_addr[5:0]] : 8'h00;
				end else begin
					wait_left--;
				end
			end
		end
	end

	// **************************************************
	// Test sequence
	// **************************************************
	initial begin
		int cyc;
		int t;
		int total;
		$readmemh("test/cpu_stimulus.mem", stim);
		n_rec = 0;
		while (n_rec < 20 && stim[64 + 3 * n_rec] !== 8'hFF) n_rec++;

		cyc = 0;
		do begin
			@(negedge i_clk);
			cyc++;
			if (i_rst) begin
				assert (!o_read && !o_write && !o_io) else begin
					$display("Error at %0d ns: o_read o_write o_io expected 000 got %b%b%b",
					         $time, o_read, o_write, o_io);
					errors[1]++;
				end
			end
		end while (i_rst && cyc < 20);
		assert (!i_rst) else begin
			$display("Reset was never released");
			errors[1]++;
		end

		cyc = 0;
		while (!o_read && cyc < 10) begin
			@(negedge i_clk);
			cyc++;
		end
		assert (o_read) else begin
			$display("No read strobe rose after reset");
			errors[1]++;
		end
		assert (o_addr == 16'h0000) else begin
			$display("Error at %0d ns: o_addr expected 0000 got %h", $time, o_addr);
			errors[1]++;
		end
		assert (!o_write && !o_io) else begin
			$display("Error at %0d ns: o_write o_io expected 00 got %b%b",
			         $time, o_write, o_io);
			errors[1]++;
		end
		report_test(1);

		cyc = 0;
		while (!halted && cyc < 3000) begin
			@(negedge i_clk);
			cyc++;
		end
		assert (halted) else begin
			$display("Program did not reach HLT in time");
			errors[6]++;
		end

		// Halted core must stay silent
		for (cyc = 0; cyc < 200; cyc++) begin
			@(negedge i_clk);
			assert (!o_read && !o_write) else begin
				$display("Bus strobe rose after HLT at %0d ns", $time);
				errors[6]++;
			end
		end
		assert (widx == n_rec) else begin
			$display("Only %0d of %0d expected port writes were seen", widx, n_rec);
			errors[6]++;
		end

		for (t = 2; t <= 6; t++) begin
			if (!reported[t]) report_test(t);
		end
		total = 0;
		for (t = 1; t <= 6; t++) total += errors[t];
		$display("Tests passed %0d, failed %0d", passed, failed);
		if (failed == 0 && total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset drops on a rising edge, like any other driven input
	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

/* rtl/cpu8080_core.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu8080_core
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_ready,
	input  logic [`CPU_DATA_W-1:0] i_dat_r,
	output logic [`CPU_ADDR_W-1:0] o_addr,
	output logic                   o_read,
	output logic                   o_write,
	output logic [`CPU_DATA_W-1:0] o_dat_w,
	output logic                   o_io
);

	logic                   port_cycle;
	logic                   pc_inc;
	logic                   pc_load;
	reg_code_e              wr_sel;
	wr_src_e                wr_src;
	reg_code_e              src_sel;
	logic                   flag_we;
	logic                   latch_lo;
	alu_op_e                alu_op;
	logic                   alu_imm;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_DATA_W-1:0] reg_a;
	logic [`CPU_DATA_W-1:0] src_byte;
	logic [FLAG_W-1:0]      flags;
	logic [FLAG_W-1:0]      flags_next;
	logic [`CPU_ADDR_W-1:0] target;
	logic [`CPU_DATA_W-1:0] alu_result;

	// OUT drives the port number on both address bytes
	assign o_addr  = port_cycle ? {2{target[`CPU_DATA_W-1:0]}} : pc;
	assign o_dat_w = reg_a;

	sequencer sequencer_inst (
		.i_clk(i_clk), .i_rst(i_rst), .i_ready(i_ready), .i_dat_r(i_dat_r),
		.i_flags(flags), .o_read(o_read), .o_write(o_write), .o_io(o_io),
		.o_port_cycle(port_cycle), .o_pc_inc(pc_inc), .o_pc_load(pc_load),
		.o_wr_sel(wr_sel), .o_wr_src(wr_src), .o_src_sel(src_sel),
		.o_flag_we(flag_we), .o_latch_lo(latch_lo), .o_alu_op(alu_op), .o_alu_imm(alu_imm)
	);

	program_counter program_counter_inst (
		.i_clk(i_clk), .i_rst(i_rst), .i_inc(pc_inc), .i_load(pc_load),
		.i_target(target), .o_pc(pc)
	);

	register_file register_file_inst (
		.i_clk(i_clk), .i_rst(i_rst), .i_wr_sel(wr_sel), .i_wr_src(wr_src),
		.i_src_sel(src_sel), .i_bus_byte(i_dat_r), .i_alu_result(alu_result),
		.i_flag_we(flag_we), .i_flags_next(flags_next), .i_latch_lo(latch_lo),
		.o_reg_a(reg_a), .o_src_byte(src_byte), .o_flags(flags), .o_target(target)
	);

	alu alu_inst (
		.i_op(alu_op), .i_a(reg_a), .i_operand(src_byte), .i_imm_byte(i_dat_r),
		.i_use_imm(alu_imm), .i_flags(flags), .o_result(alu_result),
		.o_flags_next(flags_next)
	);

endmodule

/* rtl/sequencer.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module sequencer
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_ready,
	input  logic [`CPU_DATA_W-1:0] i_dat_r,
	input  logic [FLAG_W-1:0]      i_flags,
	output logic                   o_read,
	output logic                   o_write,
	output logic                   o_io,
	output logic                   o_port_cycle,
	output logic                   o_pc_inc,
	output logic                   o_pc_load,
	output reg_code_e              o_wr_sel,
	output wr_src_e                o_wr_src,
	output reg_code_e              o_src_sel,
	output logic                   o_flag_we,
	output logic                   o_latch_lo,
	output alu_op_e                o_alu_op,
	output logic                   o_alu_imm
);

	seq_state_e             state;
	seq_state_e             state_next;
	logic [`CPU_DATA_W-1:0] ir;
	logic [`CPU_DATA_W-1:0] op;
	logic                   adv;
	logic                   cond_true;
	reg_code_e              dst;
	reg_code_e              src;
	alu_op_e                grp_op;
	alu_op_e                acc_op;
	logic                   is_mov;
	logic                   is_mvi;
	logic                   is_inr;
	logic                   is_dcr;
	logic                   is_alu_r;
	logic                   is_alu_i;
	logic                   is_jcc;
	logic                   is_acc;

	// **************************************************
	// Decode
	// **************************************************

	// S_EXEC has no bus cycle, every other step waits for i_ready
	assign adv    = (state == S_EXEC) | ((o_read | o_write) & i_ready);
	assign op     = (state == S_FETCH) ? i_dat_r : ir;
	assign dst    = reg_code_e'(op[5:3]);
	assign src    = reg_code_e'(op[2:0]);
	assign grp_op = alu_op_e'({2'b00, op[5:3]});

	// M operands decode as illegal and fall through like NOP
	assign is_mov   = ((op & 8'hC0) == OP_MOV) && (dst != REG_M) && (src != REG_M);
	assign is_mvi   = ((op & 8'hC7) == OP_MVI) && (dst != REG_M);
	assign is_inr   = ((op & 8'hC7) == OP_INR) && (dst != REG_M);
	assign is_dcr   = ((op & 8'hC7) == OP_DCR) && (dst != REG_M);
	assign is_alu_r = ((op & 8'hC0) == OP_ALU_R) && (src != REG_M);
	assign is_alu_i = (op & 8'hC7) == OP_ALU_I;
	assign is_jcc   = (op & 8'hC7) == OP_JCC;
	// Slot 4 of this group is DAA, not supported
	assign is_acc   = ((op & 8'hC7) == OP_RLC) && (op[5:3] != 3'd4);

	always_comb begin
		case (op)
			OP_RRC:  acc_op = ALU_RRC;
			OP_RAL:  acc_op = ALU_RAL;
			OP_RAR:  acc_op = ALU_RAR;
			OP_CMA:  acc_op = ALU_CMA;
			OP_STC:  acc_op = ALU_STC;
			OP_CMC:  acc_op = ALU_CMC;
			default: acc_op = ALU_RLC;
		endcase
	end

	// P means sign clear only
	always_comb begin
		case (cond_e'(op[5:3]))
			CC_NZ:   cond_true = !i_flags[FLAG_Z];
			CC_Z:    cond_true = i_flags[FLAG_Z];
			CC_NC:   cond_true = !i_flags[FLAG_CY];
			CC_C:    cond_true = i_flags[FLAG_CY];
			CC_PO:   cond_true = !i_flags[FLAG_P];
			CC_PE:   cond_true = i_flags[FLAG_P];
			CC_P:    cond_true = !i_flags[FLAG_S];
			default: cond_true = i_flags[FLAG_S];
		endcase
	end

	// **************************************************
	// Step control
	// **************************************************
	always_comb begin
		state_next = state;
		o_pc_inc   = 1'b0;
		o_pc_load  = 1'b0;
		o_wr_sel   = REG_A;
		o_wr_src   = WR_NONE;
		o_src_sel  = src;
		o_flag_we  = 1'b0;
		o_latch_lo = 1'b0;
		o_alu_op   = grp_op;
		o_alu_imm  = 1'b0;
		case (state)
			S_FETCH: if (adv) begin
				o_pc_inc = 1'b1;
				if (op == OP_HLT) state_next = S_HALT;
				else if (op == OP_JMP || is_jcc) state_next = S_ADDR_LO;
				else if (is_mvi || is_alu_i || op == OP_OUT) state_next = S_IMM;
				else if (is_mov || is_inr || is_dcr || is_alu_r || is_acc) state_next = S_EXEC;
			end
			S_EXEC: begin
				state_next = S_FETCH;
				o_wr_src   = WR_ALU;
				o_flag_we  = !is_mov;
				if (is_mov) begin
					o_wr_sel = dst;
					o_wr_src = WR_REG;
				end else if (is_inr || is_dcr) begin
					o_wr_sel  = dst;
					o_src_sel = dst;
					o_alu_op  = is_inr ? ALU_INR : ALU_DCR;
				end else if (is_alu_r) begin
					// CMP only sets flags
					if (grp_op == ALU_CMP) o_wr_src = WR_NONE;
				end else begin
					o_alu_op = acc_op;
				end
			end
			S_IMM: if (adv) begin
				o_pc_inc   = 1'b1;
				o_latch_lo = 1'b1;
				state_next = (op == OP_OUT) ? S_OUT_WR : S_FETCH;
				if (is_mvi) begin
					o_wr_sel = dst;
					o_wr_src = WR_BUS;
				end else if (is_alu_i) begin
					o_wr_src  = (grp_op == ALU_CMP) ? WR_NONE : WR_ALU;
					o_flag_we = 1'b1;
					o_alu_imm = 1'b1;
				end
			end
			S_ADDR_LO: if (adv) begin
				o_pc_inc   = 1'b1;
				o_latch_lo = 1'b1;
				state_next = S_ADDR_HI;
			end
			// Not-taken jumps still step past the high byte
			S_ADDR_HI: if (adv) begin
				o_pc_inc   = 1'b1;
				o_pc_load  = (op == OP_JMP) || (is_jcc && cond_true);
				state_next = S_FETCH;
			end
			S_OUT_WR: if (adv) state_next = S_FETCH;
			default: state_next = S_HALT;
		endcase
	end

	assign o_port_cycle = (state == S_OUT_WR);

	// Strobes follow the next state so they rise with it
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= S_FETCH;
			o_read  <= 1'b0;
			o_write <= 1'b0;
			o_io    <= 1'b0;
		end else begin
			state   <= state_next;
			o_read  <= state_next inside {S_FETCH, S_IMM, S_ADDR_LO, S_ADDR_HI};
			o_write <= (state_next == S_OUT_WR);
			o_io    <= (state_next == S_OUT_WR);
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == S_FETCH && adv) ir <= i_dat_r;
	end

endmodule

/* rtl/program_counter.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module program_counter (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_inc,
	input  logic                   i_load,
	input  logic [`CPU_ADDR_W-1:0] i_target,
	output logic [`CPU_ADDR_W-1:0] o_pc
);

	// A taken jump wins over the byte increment
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_pc <= `CPU_RESET_PC;
		end else if (i_load) begin
			o_pc <= i_target;
		end else if (i_inc) begin
			o_pc <= o_pc + 1'b1;
		end
	end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  reg_code_e              i_wr_sel,
	input  wr_src_e                i_wr_src,
	input  reg_code_e              i_src_sel,
	input  logic [`CPU_DATA_W-1:0] i_bus_byte,
	input  logic [`CPU_DATA_W-1:0] i_alu_result,
	input  logic                   i_flag_we,
	input  logic [FLAG_W-1:0]      i_flags_next,
	input  logic                   i_latch_lo,
	output logic [`CPU_DATA_W-1:0] o_reg_a,
	output logic [`CPU_DATA_W-1:0] o_src_byte,
	output logic [FLAG_W-1:0]      o_flags,
	output logic [`CPU_ADDR_W-1:0] o_target
);

	logic [`CPU_DATA_W-1:0] r_b, r_c, r_d, r_e, r_h, r_l, r_a;
	logic [`CPU_DATA_W-1:0] wr_data;
	logic [`CPU_DATA_W-1:0] addr_lo;

	always_comb begin
		case (i_src_sel)
			REG_B:   o_src_byte = r_b;
			REG_C:   o_src_byte = r_c;
			REG_D:   o_src_byte = r_d;
			REG_E:   o_src_byte = r_e;
			REG_H:   o_src_byte = r_h;
			REG_L:   o_src_byte = r_l;
			REG_A:   o_src_byte = r_a;
			default: o_src_byte = '0;
		endcase
	end

	assign wr_data = (i_wr_src == WR_REG) ? o_src_byte :
	                 (i_wr_src == WR_BUS) ? i_bus_byte : i_alu_result;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			{r_b, r_c, r_d, r_e, r_h, r_l, r_a} <= '0;
			o_flags <= '0;
		end else begin
			if (i_wr_src != WR_NONE) begin
				case (i_wr_sel)
					REG_B:   r_b <= wr_data;
					REG_C:   r_c <= wr_data;
					REG_D:   r_d <= wr_data;
					REG_E:   r_e <= wr_data;
					REG_H:   r_h <= wr_data;
					REG_L:   r_l <= wr_data;
					REG_A:   r_a <= wr_data;
					default: ;
				endcase
			end
			if (i_flag_we) o_flags <= i_flags_next;
		end
	end

	// Low operand byte, high byte comes straight off the bus
	always_ff @(posedge i_clk) begin
		if (i_latch_lo) addr_lo <= i_bus_byte;
	end

	assign o_target = {i_bus_byte, addr_lo};
	assign o_reg_a  = r_a;

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu
	import isa_pkg::*;
(
	input  alu_op_e                i_op,
	input  logic [`CPU_DATA_W-1:0] i_a,
	input  logic [`CPU_DATA_W-1:0] i_operand,
	input  logic [`CPU_DATA_W-1:0] i_imm_byte,
	input  logic                   i_use_imm,
	input  logic [FLAG_W-1:0]      i_flags,
	output logic [`CPU_DATA_W-1:0] o_result,
	output logic [FLAG_W-1:0]      o_flags_next
);

	logic [`CPU_DATA_W-1:0] b;
	logic [`CPU_DATA_W-1:0] addend;
	logic                   is_sub;
	logic                   c_in;
	logic [`CPU_DATA_W:0]   sum;
	logic [4:0]             half;
	logic [`CPU_DATA_W-1:0] val;
	logic                   cy;
	logic                   ac;
	logic                   szp;

	assign b      = i_use_imm ? i_imm_byte : i_operand;
	assign is_sub = i_op inside {ALU_SUB, ALU_SBB, ALU_CMP};
	// Subtract as A + ~B + !borrow, carry out is the inverted borrow
	assign addend = is_sub ? ~b : b;
	assign c_in   = ((i_op == ALU_ADC || i_op == ALU_SBB) & i_flags[FLAG_CY]) ^ is_sub;
	assign sum    = {1'b0, i_a} + {1'b0, addend} + 9'(c_in);
	assign half   = {1'b0, i_a[3:0]} + {1'b0, addend[3:0]} + 5'(c_in);

	always_comb begin
		val = i_a;
		cy  = i_flags[FLAG_CY];
		ac  = i_flags[FLAG_AC];
		szp = 1'b1;
		case (i_op)
			ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_CMP: begin
				val = sum[`CPU_DATA_W-1:0];
				cy  = sum[`CPU_DATA_W] ^ is_sub;
				ac  = half[4];
			end
			ALU_ANA: {val, cy, ac} = {i_a & b, 1'b0, i_a[3] | b[3]};
			ALU_XRA: {val, cy, ac} = {i_a ^ b, 2'b00};
			ALU_ORA: {val, cy, ac} = {i_a | b, 2'b00};
			// INR and DCR leave the carry alone
			ALU_INR: {val, ac} = {b + 8'd1, b[3:0] == 4'hF};
			ALU_DCR: {val, ac} = {b - 8'd1, b[3:0] != 4'h0};
			ALU_RLC: {val, cy, szp} = {i_a[6:0], i_a[7], i_a[7], 1'b0};
			ALU_RRC: {val, cy, szp} = {i_a[0], i_a[7:1], i_a[0], 1'b0};
			ALU_RAL: {val, cy, szp} = {i_a[6:0], i_flags[FLAG_CY], i_a[7], 1'b0};
			ALU_RAR: {val, cy, szp} = {i_flags[FLAG_CY], i_a[7:1], i_a[0], 1'b0};
			ALU_CMA: {val, szp} = {~i_a, 1'b0};
			ALU_STC: {cy, szp} = 2'b10;
			default: {cy, szp} = {~i_flags[FLAG_CY], 1'b0};
		endcase
	end

	always_comb begin
		o_flags_next          = i_flags;
		o_flags_next[FLAG_CY] = cy;
		o_flags_next[FLAG_AC] = ac;
		if (szp) begin
			o_flags_next[FLAG_S] = val[7];
			o_flags_next[FLAG_Z] = (val == '0);
			o_flags_next[FLAG_P] = ~^val;
		end
	end

	// CMP keeps A
	assign o_result = (i_op == ALU_CMP) ? i_a : val;

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [2:0] {
		S_FETCH,
		S_EXEC,
		S_IMM,
		S_ADDR_LO,
		S_ADDR_HI,
		S_OUT_WR,
		S_HALT
	} seq_state_e;

	// Value taken by a register write
	typedef enum logic [1:0] {
		WR_NONE,
		WR_REG,
		WR_BUS,
		WR_ALU
	} wr_src_e;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

	// Flag vector layout {S, Z, AC, P, CY}
	localparam int FLAG_W  = 5;
	localparam int FLAG_CY = 0;
	localparam int FLAG_P  = 1;
	localparam int FLAG_AC = 2;
	localparam int FLAG_Z  = 3;
	localparam int FLAG_S  = 4;

	typedef enum logic [7:0] {
		OP_NOP   = 8'h00,
		OP_RLC   = 8'h07,
		OP_RRC   = 8'h0F,
		OP_RAL   = 8'h17,
		OP_RAR   = 8'h1F,
		OP_CMA   = 8'h2F,
		OP_STC   = 8'h37,
		OP_CMC   = 8'h3F,
		OP_HLT   = 8'h76,
		OP_JMP   = 8'hC3,
		OP_OUT   = 8'hD3,
		// Group base codes, compared under a mask
		OP_INR   = 8'h04,
		OP_DCR   = 8'h05,
		OP_MVI   = 8'h06,
		OP_MOV   = 8'h40,
		OP_ALU_R = 8'h80,
		OP_JCC   = 8'hC2,
		OP_ALU_I = 8'hC6
	} opcode_e;

	typedef enum logic [2:0] {
		REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_M, REG_A
	} reg_code_e;

	// First eight follow opcode bits 5:3; seventeen ops need five bits
	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP,
		ALU_INR, ALU_DCR, ALU_RLC, ALU_RRC, ALU_RAL, ALU_RAR, ALU_CMA, ALU_STC,
		ALU_CMC
	} alu_op_e;

	typedef enum logic [2:0] {
		CC_NZ, CC_Z, CC_NC, CC_C, CC_PO, CC_PE, CC_P, CC_M
	} cond_e;

endpackage

/* rtl/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Address of the first opcode fetch after reset
`define CPU_RESET_PC 16'h0000

`endif
